/* hw/issue_cfg.svh */
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// Width of a data word, of the register file entries and of the ALU.
`define ISSUE_XLEN 32

// Register address width, so the register file has 2**5 entries.
`define ISSUE_REG_AW 5

// Number of 32-bit words in the load unit's data memory.
`define ISSUE_DMEM_WORDS 16

// Cycles from the edge that accepts a load to the edge that raises its writeback request.
`define ISSUE_LOAD_LAT 3

`endif

/* hw/issue_pkg.sv */
`include "issue_cfg.svh"

package issue_pkg;

    // Register-register layout of an instruction word.
    typedef struct packed {
        logic [6:0]               funct7;
        logic [`ISSUE_REG_AW-1:0] rs2;
        logic [`ISSUE_REG_AW-1:0] rs1;
        logic [2:0]               funct3;
        logic [`ISSUE_REG_AW-1:0] rd;
        logic [6:0]               opcode;
    } r_fmt_t;

    // Immediate layout; the 12-bit immediate overlays funct7 and rs2.
    typedef struct packed {
        logic [11:0]              imm;
        logic [`ISSUE_REG_AW-1:0] rs1;
        logic [2:0]               funct3;
        logic [`ISSUE_REG_AW-1:0] rd;
        logic [6:0]               opcode;
    } i_fmt_t;

    // One instruction word, read through whichever view the opcode calls for.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    // ALU operations of the supported subset. ADDI uses ADD.
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR
    } alu_op_e;

    // A load as handed from the issue controller to the load unit.
    typedef struct packed {
        logic [`ISSUE_REG_AW-1:0] rd;
        logic [`ISSUE_XLEN-1:0]   base;
        logic [11:0]              offset;
    } load_req_t;

endpackage

/* hw/wb_if.sv */
`include "issue_cfg.svh"

// Four-phase writeback channel between one result producer and the arbiter.
interface wb_if;

    logic                     req;
    logic                     ack;
    logic [`ISSUE_REG_AW-1:0] rd;
    logic [`ISSUE_XLEN-1:0]   data;

    // The producer holds req, rd and data until it has seen ack.
    modport peer (
        output req,
        output rd,
        output data,
        input  ack
    );

    // The arbiter raises ack on the grant edge and drops it once req is low.
    modport arbiter (
        input  req,
        input  rd,
        input  data,
        output ack
    );

endinterface

/* hw/reg_file.sv */
`include "issue_cfg.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`ISSUE_REG_AW-1:0] raddr1,
    input  logic [`ISSUE_REG_AW-1:0] raddr2,
    output logic [`ISSUE_XLEN-1:0]   rdata1,
    output logic [`ISSUE_XLEN-1:0]   rdata2,
    input  logic                     we,
    input  logic [`ISSUE_REG_AW-1:0] waddr,
    input  logic [`ISSUE_XLEN-1:0]   wdata
);

    localparam int NREGS = 1 << `ISSUE_REG_AW;

    logic [`ISSUE_XLEN-1:0] regs [NREGS];

    // Both read ports are combinational, so an operand written on an edge
    // is visible to the instruction accepted on the following edge.
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // Entry 0 is cleared at reset and never written, which keeps x0 at zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

/* hw/hazard_stall.sv */
`include "issue_cfg.svh"

module hazard_stall (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`ISSUE_REG_AW-1:0] rs1,
    input  logic [`ISSUE_REG_AW-1:0] rs2,
    input  logic [`ISSUE_REG_AW-1:0] rd,
    input  logic                     uses_rs2,
    input  logic                     issue,
    input  logic                     clr_valid,
    input  logic [`ISSUE_REG_AW-1:0] clr_rd,
    output logic                     stall
);

    localparam int NREGS = 1 << `ISSUE_REG_AW;

    // One busy bit per register except x0, which is never reserved.
    logic [NREGS-1:1] busy;
    logic [NREGS-1:0] busy_vec;
    logic [NREGS-1:1] set_mask;
    logic [NREGS-1:1] clr_mask;

    // Bit 0 reads as free so that x0 operands never stall.
    assign busy_vec = {busy, 1'b0};

    // Decode the register being reserved and the register being retired.
    always_comb begin
        for (int i = 1; i < NREGS; i++) begin
            set_mask[i] = issue && (rd == i);
            clr_mask[i] = clr_valid && (clr_rd == i);
        end
    end

    // A clear and a set can land on the same edge for different registers.
    // The stall rule keeps them apart, since rd is never issued while busy.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~clr_mask) | set_mask;
        end
    end

    // Read-after-write on rs1 and rs2, and write-after-write on rd.
    // rs2 only counts for register-register instructions.
    assign stall = busy_vec[rs1] | (uses_rs2 & busy_vec[rs2]) | busy_vec[rd];

endmodule

/* hw/issue_ctrl.sv */
`include "issue_cfg.svh"

module issue_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_req,
    input  issue_pkg::instr_t        in_instr,
    output logic                     in_ack,
    output logic [`ISSUE_REG_AW-1:0] rs1,
    output logic [`ISSUE_REG_AW-1:0] rs2,
    output logic [`ISSUE_REG_AW-1:0] rd,
    output logic                     uses_rs2,
    input  logic                     stall,
    output logic                     issue,
    output logic [`ISSUE_REG_AW-1:0] rf_raddr1,
    output logic [`ISSUE_REG_AW-1:0] rf_raddr2,
    input  logic [`ISSUE_XLEN-1:0]   rf_rdata1,
    input  logic [`ISSUE_XLEN-1:0]   rf_rdata2,
    output issue_pkg::load_req_t     ld_req,
    output logic                     ld_start,
    input  logic                     ld_busy,
    output logic                     illegal,
    wb_if.peer                       wb
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    logic                   is_rtype;
    logic                   is_addi;
    logic                   is_load;
    logic                   legal;
    logic                   has_rd;
    issue_pkg::alu_op_e     alu_op;
    logic [`ISSUE_XLEN-1:0] imm_sext;
    logic [`ISSUE_XLEN-1:0] op_b;
    logic [`ISSUE_XLEN-1:0] alu_result;
    logic                   alu_pend;
    logic                   wb_busy;
    logic                   ready;
    logic                   accept;
    logic                   alu_go;

    // rs1, rd and opcode sit at the same bits in both views.
    assign rs1       = in_instr.r_fmt.rs1;
    assign rs2       = in_instr.r_fmt.rs2;
    assign rd        = in_instr.r_fmt.rd;
    assign rf_raddr1 = rs1;
    assign rf_raddr2 = rs2;
    assign has_rd    = (rd != '0);

    // The R-type view supplies funct7. The I-type view supplies the immediate.
    always_comb begin
        is_rtype = 1'b0;
        is_addi  = 1'b0;
        is_load  = 1'b0;
        alu_op   = issue_pkg::ADD;
        case (in_instr.r_fmt.opcode)
            OPC_OP: begin
                is_rtype = 1'b1;
                case ({in_instr.r_fmt.funct7, in_instr.r_fmt.funct3})
                    {7'b0000000, 3'b000}: alu_op = issue_pkg::ADD;
                    {7'b0100000, 3'b000}: alu_op = issue_pkg::SUB;
                    {7'b0000000, 3'b111}: alu_op = issue_pkg::AND;
                    {7'b0000000, 3'b110}: alu_op = issue_pkg::OR;
                    {7'b0000000, 3'b100}: alu_op = issue_pkg::XOR;
                    default:              is_rtype = 1'b0;
                endcase
            end
            OPC_OP_IMM: is_addi = (in_instr.i_fmt.funct3 == 3'b000);
            OPC_LOAD:   is_load = (in_instr.i_fmt.funct3 == 3'b010);
            default:    ;
        endcase
    end

    assign legal    = is_rtype | is_addi | is_load;
    assign uses_rs2 = is_rtype;

    // ADDI takes the sign-extended immediate as its second operand.
    assign imm_sext = {{(`ISSUE_XLEN - 12){in_instr.i_fmt.imm[11]}}, in_instr.i_fmt.imm};
    assign op_b     = is_rtype ? rf_rdata2 : imm_sext;

    always_comb begin
        case (alu_op)
            issue_pkg::SUB: alu_result = rf_rdata1 - op_b;
            issue_pkg::AND: alu_result = rf_rdata1 & op_b;
            issue_pkg::OR:  alu_result = rf_rdata1 | op_b;
            issue_pkg::XOR: alu_result = rf_rdata1 ^ op_b;
            default:        alu_result = rf_rdata1 + op_b;
        endcase
    end

    // The ALU result register is in use from acceptance until ack falls.
    assign wb_busy = alu_pend | wb.req | wb.ack;

    // Illegal words need no resources and are discarded as soon as they arrive.
    assign ready  = legal ? (~stall & ~wb_busy & ~(is_load & ld_busy)) : 1'b1;
    assign accept = in_req & ~in_ack & ready;
    assign alu_go = accept & (is_rtype | is_addi) & has_rd;

    // Writes to x0 reserve nothing and never reach the writeback path.
    assign issue    = accept & legal & has_rd;
    assign ld_start = accept & is_load & has_rd;

    assign ld_req.rd     = rd;
    assign ld_req.base   = rf_rdata1;
    assign ld_req.offset = in_instr.i_fmt.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack   <= 1'b0;
            illegal  <= 1'b0;
            alu_pend <= 1'b0;
            wb.req   <= 1'b0;
        end else begin
            // in_ack rises on the accepting edge and follows in_req down.
            in_ack   <= in_ack ? in_req : accept;
            illegal  <= accept & ~legal;
            alu_pend <= alu_go;
            // The request goes out one edge after the instruction is accepted.
            if (alu_pend) begin
                wb.req <= 1'b1;
            end else if (wb.ack) begin
                wb.req <= 1'b0;
            end
        end
    end

    // The result and its destination stay put until the handshake is over.
    always_ff @(posedge clk) begin
        if (alu_go) begin
            wb.rd   <= rd;
            wb.data <= alu_result;
        end
    end

endmodule

/* hw/load_unit.sv */
`include "issue_cfg.svh"

module load_unit (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  issue_pkg::load_req_t                 req,
    input  logic                                 start,
    output logic                                 busy,
    input  logic                                 dmem_we,
    input  logic [$clog2(`ISSUE_DMEM_WORDS)-1:0] dmem_addr,
    input  logic [`ISSUE_XLEN-1:0]               dmem_wdata,
    wb_if.peer                                   wb
);

    localparam int IDX_W = $clog2(`ISSUE_DMEM_WORDS);
    localparam int CNT_W = $clog2(`ISSUE_LOAD_LAT + 1);

    logic [`ISSUE_XLEN-1:0] mem [`ISSUE_DMEM_WORDS];
    logic [`ISSUE_XLEN-1:0] addr;
    logic [IDX_W-1:0]       idx;
    logic [CNT_W-1:0]       cnt;
    logic                   waiting;

    // Effective byte address; bits 5 to 2 select the word.
    assign addr = req.base + {{(`ISSUE_XLEN - 12){req.offset[11]}}, req.offset};

    // Preload port, used before any instruction is issued.
    always_ff @(posedge clk) begin
        if (dmem_we) begin
            mem[dmem_addr] <= dmem_wdata;
        end
    end

    // The counter runs down from the start edge.
    // The request rises ISSUE_LOAD_LAT edges after start.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waiting <= 1'b0;
            cnt     <= '0;
            wb.req  <= 1'b0;
        end else if (start) begin
            waiting <= 1'b1;
            cnt     <= CNT_W'(`ISSUE_LOAD_LAT - 1);
        end else if (waiting) begin
            if (cnt == '0) begin
                waiting <= 1'b0;
                wb.req  <= 1'b1;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end else if (wb.req && wb.ack) begin
            wb.req <= 1'b0;
        end
    end

    // The unit takes one load at a time, up to the end of its writeback.
    assign busy = waiting | wb.req;

    always_ff @(posedge clk) begin
        if (start) begin
            idx   <= addr[2 +: IDX_W];
            wb.rd <= req.rd;
        end
        // Memory is read as the request goes out, so data is valid with req.
        if (waiting && (cnt == '0)) begin
            wb.data <= mem[idx];
        end
    end

endmodule

/* hw/wb_arbiter.sv */
`include "issue_cfg.svh"

module wb_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    wb_if.arbiter                    alu_wb,
    wb_if.arbiter                    ld_wb,
    output logic                     rf_we,
    output logic [`ISSUE_REG_AW-1:0] rf_waddr,
    output logic [`ISSUE_XLEN-1:0]   rf_wdata,
    output logic                     wb_valid,
    output logic [`ISSUE_REG_AW-1:0] wb_rd,
    output logic [`ISSUE_XLEN-1:0]   wb_data
);

    logic idle;
    logic grant_ld;
    logic grant_alu;

    // No new grant while either handshake is still winding down.
    // A peer that loses waits out the winner's full round trip.
    assign idle      = ~alu_wb.ack & ~ld_wb.ack;
    assign grant_ld  = idle & ld_wb.req;
    assign grant_alu = idle & alu_wb.req & ~ld_wb.req;

    // Single register file write port. It also clears the busy bit.
    assign rf_we    = grant_ld | grant_alu;
    assign rf_waddr = grant_ld ? ld_wb.rd : alu_wb.rd;
    assign rf_wdata = grant_ld ? ld_wb.data : alu_wb.data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_wb.ack  <= 1'b0;
            alu_wb.ack <= 1'b0;
            wb_valid   <= 1'b0;
        end else begin
            // ack goes up with the write and down once the peer drops req.
            if (grant_ld) begin
                ld_wb.ack <= 1'b1;
            end else if (!ld_wb.req) begin
                ld_wb.ack <= 1'b0;
            end
            if (grant_alu) begin
                alu_wb.ack <= 1'b1;
            end else if (!alu_wb.req) begin
                alu_wb.ack <= 1'b0;
            end
            wb_valid <= rf_we;
        end
    end

    // Retire record of the write, valid while wb_valid is high.
    always_ff @(posedge clk) begin
        if (rf_we) begin
            wb_rd   <= rf_waddr;
            wb_data <= rf_wdata;
        end
    end

endmodule

/* hw/issue_core.sv */
`include "issue_cfg.svh"

module issue_core (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_req,
    input  issue_pkg::instr_t                    in_instr,
    output logic                                 in_ack,
    input  logic                                 dmem_we,
    input  logic [$clog2(`ISSUE_DMEM_WORDS)-1:0] dmem_addr,
    input  logic [`ISSUE_XLEN-1:0]               dmem_wdata,
    output logic                                 wb_valid,
    output logic [`ISSUE_REG_AW-1:0]             wb_rd,
    output logic [`ISSUE_XLEN-1:0]               wb_data,
    output logic                                 illegal
);

    logic [`ISSUE_REG_AW-1:0] rs1;
    logic [`ISSUE_REG_AW-1:0] rs2;
    logic [`ISSUE_REG_AW-1:0] rd;
    logic                     uses_rs2;
    logic                     stall;
    logic                     issue;
    logic [`ISSUE_REG_AW-1:0] rf_raddr1;
    logic [`ISSUE_REG_AW-1:0] rf_raddr2;
    logic [`ISSUE_XLEN-1:0]   rf_rdata1;
    logic [`ISSUE_XLEN-1:0]   rf_rdata2;
    issue_pkg::load_req_t     ld_req;
    logic                     ld_start;
    logic                     ld_busy;
    logic                     rf_we;
    logic [`ISSUE_REG_AW-1:0] rf_waddr;
    logic [`ISSUE_XLEN-1:0]   rf_wdata;

    // One writeback channel per result producer.
    wb_if alu_wb ();
    wb_if ld_wb ();

    issue_ctrl i_issue_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_instr  (in_instr),
        .in_ack    (in_ack),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .uses_rs2  (uses_rs2),
        .stall     (stall),
        .issue     (issue),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .ld_req    (ld_req),
        .ld_start  (ld_start),
        .ld_busy   (ld_busy),
        .illegal   (illegal),
        .wb        (alu_wb.peer)
    );

    // The register file write doubles as the busy-bit clear.
    hazard_stall i_hazard_stall (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .uses_rs2  (uses_rs2),
        .issue     (issue),
        .clr_valid (rf_we),
        .clr_rd    (rf_waddr),
        .stall     (stall)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    load_unit i_load_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (ld_req),
        .start      (ld_start),
        .busy       (ld_busy),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .wb         (ld_wb.peer)
    );

    wb_arbiter i_wb_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .alu_wb   (alu_wb.arbiter),
        .ld_wb    (ld_wb.arbiter),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

/* bench/issue_core_assertions.sv */
`include "issue_cfg.svh"

module issue_core_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_req,
    input logic                     in_ack,
    input logic                     alu_req,
    input logic                     alu_ack,
    input logic [`ISSUE_REG_AW-1:0] alu_rd,
    input logic [`ISSUE_XLEN-1:0]   alu_data,
    input logic                     ld_req,
    input logic                     ld_ack,
    input logic [`ISSUE_REG_AW-1:0] ld_rd,
    input logic [`ISSUE_XLEN-1:0]   ld_data
);

    // A writeback request is held until the arbiter answers it.
    alu_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        alu_req && !alu_ack |=> alu_req)
        else $error("ALU writeback req dropped before ack");

    ld_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        ld_req && !ld_ack |=> ld_req)
        else $error("load writeback req dropped before ack");

    // Destination and result must not move under a pending request.
    alu_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
        alu_req && !alu_ack |=> $stable(alu_rd) && $stable(alu_data))
        else $error("ALU writeback payload changed while req was high");

    ld_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ld_req && !ld_ack |=> $stable(ld_rd) && $stable(ld_data))
        else $error("load writeback payload changed while req was high");

    // in_ack rises on the edge that saw in_req high.
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

    // Each grant raises its peer's ack, so two grants at once would show
    // up as both acks high together.
    one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_ack && ld_ack))
        else $error("both writeback peers granted in one cycle");

endmodule

bind issue_core issue_core_assertions i_issue_core_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .alu_req  (alu_wb.req),
    .alu_ack  (alu_wb.ack),
    .alu_rd   (alu_wb.rd),
    .alu_data (alu_wb.data),
    .ld_req   (ld_wb.req),
    .ld_ack   (ld_wb.ack),
    .ld_rd    (ld_wb.rd),
    .ld_data  (ld_wb.data)
);

/* bench/tb_issue_core.sv */
`include "issue_cfg.svh"

module tb_issue_core;

    localparam int WAIT_LIMIT = 200;
    localparam int DMEM_AW    = $clog2(`ISSUE_DMEM_WORDS);

    logic                     clk;
    logic                     rst_n;
    logic                     in_req;
    issue_pkg::instr_t        in_instr;
    logic                     in_ack;
    logic                     dmem_we;
    logic [DMEM_AW-1:0]       dmem_addr;
    logic [`ISSUE_XLEN-1:0]   dmem_wdata;
    logic                     wb_valid;
    logic [`ISSUE_REG_AW-1:0] wb_rd;
    logic [`ISSUE_XLEN-1:0]   wb_data;
    logic                     illegal;

    // Preload words and instructions, in trace order.
    logic [DMEM_AW-1:0]       pre_addr [$];
    logic [`ISSUE_XLEN-1:0]   pre_data [$];
    logic [31:0]              ins_word [$];
    logic                     ins_bad  [$];
    logic [`ISSUE_REG_AW-1:0] ins_rd   [$];
    logic [`ISSUE_XLEN-1:0]   ins_val  [$];

    // Accepted instructions that still owe a retire.
    logic [`ISSUE_REG_AW-1:0] pend_rd  [$];
    logic [`ISSUE_XLEN-1:0]   pend_val [$];

    int errors;
    int timeouts;
    int checks;

    issue_core i_issue_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_instr   (in_instr),
        .in_ack     (in_ack),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .illegal    (illegal)
    );

    always #20 clk = ~clk;

    // Each trace line starts with a letter that tells its kind.
    task automatic read_trace();
        int          fd;
        int          n;
        int          r;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("bench/issue_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/issue_trace.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = 0;
                r = 0;
                a = '0;
                b = '0;
                case (line.getc(0))
                    "M": begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                        pre_addr.push_back(a[DMEM_AW-1:0]);
                        pre_data.push_back(b);
                        n = n + 1;
                    end
                    "I": begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%h %d %h", a, r, b);
                        ins_word.push_back(a);
                        ins_bad.push_back(1'b0);
                        ins_rd.push_back(r[`ISSUE_REG_AW-1:0]);
                        ins_val.push_back(b);
                    end
                    "X": begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%h", a);
                        ins_word.push_back(a);
                        ins_bad.push_back(1'b1);
                        ins_rd.push_back('0);
                        ins_val.push_back('0);
                        n = n + 2;
                    end
                    default: n = 3;
                endcase
                // Every data line yields three fields once its kind is counted.
                if (n != 3) begin
                    $display("Malformed trace line: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Runs one instruction through the four-phase input handshake.
    task automatic send_instr(input int idx);
        int n;
        in_req   = 1'b1;
        in_instr = ins_word[idx];
        n        = 0;
        @(negedge clk);
        while (!in_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!in_ack) begin
            $display("Timeout: instruction %08h was never accepted", ins_word[idx]);
            timeouts++;
            in_req = 1'b0;
        end else begin
            // illegal pulses together with the rise of in_ack.
            checks++;
            if (illegal !== ins_bad[idx]) begin
                $display("[ERROR] %0t illegal: expected %b, got %b",
                         $time, ins_bad[idx], illegal);
                errors++;
            end
            // Only legal words with a real destination owe a retire.
            if (!ins_bad[idx] && ins_rd[idx] != '0) begin
                pend_rd.push_back(ins_rd[idx]);
                pend_val.push_back(ins_val[idx]);
            end
            in_req = 1'b0;
            n      = 0;
            while (in_ack && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (in_ack) begin
                $display("Timeout: in_ack stayed high after in_req fell");
                timeouts++;
            end
        end
    endtask

    // The stall rule leaves at most one outstanding write per register.
    task automatic check_retire(input logic [`ISSUE_REG_AW-1:0] rd,
                                input logic [`ISSUE_XLEN-1:0] data);
        int hits;
        int slot;
        hits = 0;
        slot = 0;
        foreach (pend_rd[i]) begin
            if (pend_rd[i] == rd) begin
                hits++;
                slot = i;
            end
        end
        if (hits != 1) begin
            $display("Retire of x%0d at %0t matches %0d outstanding instructions",
                     rd, $time, hits);
            errors++;
        end else begin
            checks++;
            if (data !== pend_val[slot]) begin
                $display("[ERROR] %0t wb_data (x%0d): expected %08h, got %08h",
                         $time, rd, pend_val[slot], data);
                errors++;
            end
            pend_rd.delete(slot);
            pend_val.delete(slot);
        end
    endtask

    // Retires are sampled mid-cycle, away from the rising edge.
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            check_retire(wb_rd, wb_data);
        end
    end

    initial begin
        int n;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_req     = 1'b0;
        in_instr   = '0;
        dmem_we    = 1'b0;
        dmem_addr  = '0;
        dmem_wdata = '0;
        errors     = 0;
        timeouts   = 0;
        checks     = 0;
        read_trace();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        // Data memory is filled before the first instruction goes out.
        foreach (pre_addr[i]) begin
            dmem_we    = 1'b1;
            dmem_addr  = pre_addr[i];
            dmem_wdata = pre_data[i];
            @(negedge clk);
        end
        dmem_we = 1'b0;
        @(negedge clk);
        foreach (ins_word[i]) begin
            if (timeouts == 0) begin
                send_instr(i);
            end
        end
        n = 0;
        while (pend_rd.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (pend_rd.size() != 0) begin
            $display("Timeout: %0d instructions never retired", pend_rd.size());
            timeouts++;
        end
        // A quiet stretch catches any retire that nothing asked for.
        repeat (10) @(negedge clk);
        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* bench/issue_trace.txt */
# M <word index, hex> <data, hex> preloads one data memory word.
# I <instr, hex> <rd, dec> <expected rd value, hex> (rd 0 expects no retire). X <instr, hex> is illegal.
M 4 cafe0001
M 5 00000064
M 6 12345678
M 7 0badf00d
I 12300093 1 00000123
I ffa00113 2 fffffffa
I 002081b3 3 0000011d
I 40208233 4 00000129
I 0020f2b3 5 00000122
I 0020e333 6 fffffffb
I 0020c3b3 7 fffffed9
I 01400513 10 00000014
I 01002403 8 cafe0001
I 00452483 9 12345678
I 00148633 12 1234579b
I 00852683 13 0badf00d
I 00108713 14 00000124
I 05500793 15 00000055
I 00108793 15 00000124
I 00078833 16 00000124
X 0000007f
X 02208233
I 07708013 0 00000000
I 000008b3 17 00000000

/* files.f */
+incdir+hw
hw/issue_pkg.sv
hw/wb_if.sv
hw/reg_file.sv
hw/hazard_stall.sv
hw/issue_ctrl.sv
hw/load_unit.sv
hw/wb_arbiter.sv
hw/issue_core.sv
bench/issue_core_assertions.sv
bench/tb_issue_core.sv

/* Makefile */
TOP := tb_issue_core

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
